// File: verilog/clkCtlPkg.sv
package clkCtlPkg;

  // Control group function codes, diagnostic function 00x
  typedef enum logic [2:0] {
    funcStop       = 3'd0,
    funcStart      = 3'd1,
    funcSingleStep = 3'd2,
    funcEboxSs     = 3'd3,
    funcCondSs     = 3'd4,
    funcBurst      = 3'd5,
    funcClrReset   = 3'd6,
    funcSetReset   = 3'd7
  } ctlFuncE;

  // Load group function codes, diagnostic function 04x
  // Only 042 through 045 do anything on this board
  typedef enum logic [2:0] {
    ldFunc040 = 3'd0,
    ldFunc041 = 3'd1,
    ldFunc042 = 3'd2,
    ldFunc043 = 3'd3,
    ldFunc044 = 3'd4,
    ldFunc045 = 3'd5,
    ldFunc046 = 3'd6,
    ldFunc047 = 3'd7
  } ldFuncE;

  // EBOX rate select, period of 1, 2, 4 or 8 MBOX cycles
  typedef enum logic [1:0] {
    rateFull    = 2'd0,
    rateHalf    = 2'd1,
    rateQuarter = 2'd2,
    rateEighth  = 2'd3
  } rateE;

  // Burst counter and MBOX phase counter widths
  localparam int BURST_W = 8;
  localparam int PHASE_W = 2;

  // Rate divider covers the slowest rate, 8 cycles
  localparam int DIV_W = 3;

  // Clock source select field
  localparam int SRC_W = 2;

endpackage

// File: verilog/ebusPkg.sv
package ebusPkg;

  // Diagnostic select, the low three DS bits
  localparam int DS_W = 3;

  // Load data comes from EBUS bits 32..35, MSB first
  localparam int LOAD_W = 4;

  // Readback drives EBUS bits 30..35, MSB first
  localparam int READ_W = 6;

  // Readback words selected by the diagnostic select code
  typedef enum logic [2:0] {
    rdStatus  = 3'd0,
    rdCountHi = 3'd1,
    rdCountLo = 3'd2,
    rdConfig  = 3'd3,
    rdDisable = 3'd4,
    rdSpare5  = 3'd5,
    rdSpare6  = 3'd6,
    rdSpare7  = 3'd7
  } readSelE;

endpackage

// File: verilog/diagFuncDecoder.sv
`timescale 1ns/1ps

module diagFuncDecoder (
  input  logic                     MBOX_CLK,
  input  logic                     CLK,
  input  logic                     diagCtlFunc,
  input  logic                     diagLdFunc,
  input  logic [ebusPkg::DS_W-1:0] ebusDs,
  output logic                     startFn,
  output logic                     stepFn,
  output logic                     burstFn,
  output logic                     clrResetFn,
  output logic                     setResetFn,
  output logic                     ctlFnAny,
  output logic                     ldBurstLo,
  output logic                     ldBurstHi,
  output logic                     ldRate,
  output logic                     ldDisable
);
  import clkCtlPkg::*;

  ctlFuncE ctlCode;
  ldFuncE  ldCode;

  // Same select bits, read as either function group
  assign ctlCode = ctlFuncE'(ebusDs);
  assign ldCode  = ldFuncE'(ebusDs);

  // Pulses come out one cycle after the strobe
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      startFn    <= 1'b0;
      stepFn     <= 1'b0;
      burstFn    <= 1'b0;
      clrResetFn <= 1'b0;
      setResetFn <= 1'b0;
      ctlFnAny   <= 1'b0;
      ldBurstLo  <= 1'b0;
      ldBurstHi  <= 1'b0;
      ldRate     <= 1'b0;
      ldDisable  <= 1'b0;
    end else begin
      startFn    <= diagCtlFunc && (ctlCode == funcStart);
      stepFn     <= diagCtlFunc && (ctlCode == funcSingleStep);
      burstFn    <= diagCtlFunc && (ctlCode == funcBurst);
      clrResetFn <= diagCtlFunc && (ctlCode == funcClrReset);
      setResetFn <= diagCtlFunc && (ctlCode == funcSetReset);
      // Stop, EBOX-SS and cond SS only show up here
      ctlFnAny   <= diagCtlFunc;
      ldBurstLo  <= diagLdFunc && (ldCode == ldFunc042);
      ldBurstHi  <= diagLdFunc && (ldCode == ldFunc043);
      ldRate     <= diagLdFunc && (ldCode == ldFunc044);
      ldDisable  <= diagLdFunc && (ldCode == ldFunc045);
    end
  end

endmodule

// File: verilog/clkConfigRegs.sv
`timescale 1ns/1ps

module clkConfigRegs (
  input  logic                       MBOX_CLK,
  input  logic                       CLK,
  input  logic                       ldRate,
  input  logic                       ldDisable,
  input  logic                       setResetFn,
  input  logic                       clrResetFn,
  input  logic [ebusPkg::LOAD_W-1:0] ebusData,
  output logic [clkCtlPkg::SRC_W-1:0] sourceSel,
  output clkCtlPkg::rateE            rateSel,
  output logic                       crmDis,
  output logic                       edpDis,
  output logic                       ctlDis,
  output logic                       mrReset
);
  import clkCtlPkg::*;

  // ebusData[3] is EBUS bit 32, ebusData[0] is bit 35

  // 044 source and rate select
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      sourceSel <= '0;
      rateSel   <= rateFull;
    end else if (ldRate) begin
      // Bits 32..33
      sourceSel <= ebusData[3:2];
      // Bits 34..35
      rateSel   <= rateE'(ebusData[1:0]);
    end
  end

  // 045 per-section EBOX clock disables
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      crmDis <= 1'b0;
      edpDis <= 1'b0;
      ctlDis <= 1'b0;
    end else if (ldDisable) begin
      // Bit 33 CRM, 34 EDP, 35 CTL
      crmDis <= ebusData[2];
      edpDis <= ebusData[1];
      ctlDis <= ebusData[0];
    end
  end

  // Master reset flop
  // Comes up set, only the clear-reset function drops it
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      mrReset <= 1'b1;
    end else if (setResetFn) begin
      mrReset <= 1'b1;
    end else if (clrResetFn) begin
      mrReset <= 1'b0;
    end
  end

endmodule

// File: verilog/burstControl.sv
`timescale 1ns/1ps

module burstControl #(
  parameter int BURST_W = clkCtlPkg::BURST_W
) (
  input  logic                       MBOX_CLK,
  input  logic                       CLK,
  input  logic                       startFn,
  input  logic                       stepFn,
  input  logic                       burstFn,
  input  logic                       ctlFnAny,
  input  logic                       ldBurstLo,
  input  logic                       ldBurstHi,
  input  logic [ebusPkg::LOAD_W-1:0] ebusData,
  input  clkCtlPkg::rateE            rateSel,
  output logic                       run,
  output logic                       burst,
  output logic [BURST_W-1:0]         burstCount,
  output logic                       runReq
);
  import clkCtlPkg::*;
  import ebusPkg::*;

  logic [DIV_W-1:0] divCnt;
  logic             rateTick;
  logic             stepPending;
  logic             burstLive;

  // Free-running rate divider
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + 1'b1;
    end
  end

  // One tick every 2^rateSel cycles
  always_comb begin
    case (rateSel)
      rateFull:    rateTick = 1'b1;
      rateHalf:    rateTick = (divCnt[0] == 1'b0);
      rateQuarter: rateTick = (divCnt[1:0] == 2'b00);
      default:     rateTick = (divCnt == '0);
    endcase
  end

  // Burst only requests while count is left
  assign burstLive = burst && (burstCount != '0);
  assign runReq    = rateTick && (run || burstLive || stepPending);

  // Run/burst latches follow every control function
  // A stop or the unused codes drop both
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      run         <= 1'b0;
      burst       <= 1'b0;
      stepPending <= 1'b0;
    end else begin
      if (ctlFnAny) begin
        run   <= startFn;
        burst <= burstFn;
      end
      // Step waits for the next rate tick, then it is spent
      if (stepFn) begin
        stepPending <= 1'b1;
      end else if (rateTick) begin
        stepPending <= 1'b0;
      end
    end
  end

  // Burst counter, loaded a nibble at a time by 042 and 043
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
    end else if (ldBurstLo) begin
      burstCount[LOAD_W-1:0] <= ebusData;
    end else if (ldBurstHi) begin
      burstCount[BURST_W-1 -: LOAD_W] <= ebusData;
    end else if (rateTick && burstLive) begin
      burstCount <= burstCount - 1'b1;
    end
  end

endmodule

// File: verilog/eboxSync.sv
`timescale 1ns/1ps

module eboxSync #(
  parameter int PHASE_W = clkCtlPkg::PHASE_W
) (
  input  logic               MBOX_CLK,
  input  logic               CLK,
  input  logic               runReq,
  input  logic [PHASE_W-1:0] cramTime,
  input  logic               crmDis,
  input  logic               edpDis,
  input  logic               ctlDis,
  output logic               eboxSync,
  output logic               eboxClkEn,
  output logic               crmClkEn,
  output logic               edpClkEn,
  output logic               ctlClkEn
);

  logic [PHASE_W-1:0] phase;
  logic               syncReq;

  // MBOX phase counter, restarts at each EBOX clock
  // Holds at the top so a long wait still matches any time field
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      phase <= '0;
    end else if (eboxClkEn) begin
      phase <= '0;
    end else if (phase != '1) begin
      phase <= phase + 1'b1;
    end
  end

  // Time field reached and no EBOX cycle already in flight
  assign syncReq = runReq && (phase >= cramTime) && !eboxSync && !eboxClkEn;

  // Sync leads the EBOX clock enable by exactly one cycle
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxSync  <= 1'b0;
      eboxClkEn <= 1'b0;
    end else begin
      eboxSync  <= syncReq;
      eboxClkEn <= eboxSync;
    end
  end

  // Per-section enables
  assign crmClkEn = eboxClkEn && !crmDis;
  assign edpClkEn = eboxClkEn && !edpDis;
  assign ctlClkEn = eboxClkEn && !ctlDis;

endmodule

// File: verilog/diagReadMux.sv
`timescale 1ns/1ps

module diagReadMux #(
  parameter int BURST_W = clkCtlPkg::BURST_W
) (
  input  logic                        MBOX_CLK,
  input  logic                        CLK,
  input  logic                        diagRead,
  input  logic [ebusPkg::DS_W-1:0]    ebusDs,
  input  logic                        eboxSync,
  input  logic                        run,
  input  logic                        burst,
  input  logic                        mrReset,
  input  logic [BURST_W-1:0]          burstCount,
  input  logic [clkCtlPkg::SRC_W-1:0] sourceSel,
  input  clkCtlPkg::rateE             rateSel,
  input  logic                        crmDis,
  input  logic                        edpDis,
  input  logic                        ctlDis,
  output logic                        ebusDriving,
  output logic [ebusPkg::READ_W-1:0]  ebusReadData
);
  import ebusPkg::*;

  logic              countIsZero;
  logic [READ_W-1:0] readWord;

  assign countIsZero = (burstCount == '0);

  // Word layout is EBUS bit 30 first
  always_comb begin
    case (readSelE'(ebusDs))
      rdStatus:  readWord = {eboxSync, run, burst, mrReset, countIsZero, 1'b0};
      rdCountHi: readWord = {2'b00, burstCount[BURST_W-1 -: LOAD_W]};
      rdCountLo: readWord = {2'b00, burstCount[LOAD_W-1:0]};
      rdConfig:  readWord = {sourceSel, rateSel, 2'b00};
      rdDisable: readWord = {crmDis, edpDis, ctlDis, 3'b000};
      // Selects 5..7 read back as zero
      default:   readWord = '0;
    endcase
  end

  // Bus is only driven while a diagnostic read is up
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      ebusDriving  <= 1'b0;
      ebusReadData <= '0;
    end else if (diagRead) begin
      ebusDriving  <= 1'b1;
      ebusReadData <= readWord;
    end else begin
      ebusDriving  <= 1'b0;
      ebusReadData <= '0;
    end
  end

endmodule

// File: verilog/clkControl.sv
`timescale 1ns/1ps

module clkControl #(
  parameter int BURST_W = clkCtlPkg::BURST_W,
  parameter int PHASE_W = clkCtlPkg::PHASE_W
) (
  input  logic                       MBOX_CLK,
  input  logic                       CLK,
  input  logic                       diagCtlFunc,
  input  logic                       diagLdFunc,
  input  logic [ebusPkg::DS_W-1:0]   ebusDs,
  input  logic [ebusPkg::LOAD_W-1:0] ebusData,
  input  logic                       diagRead,
  input  logic [PHASE_W-1:0]         cramTime,
  output logic                       eboxSync,
  output logic                       eboxClkEn,
  output logic                       crmClkEn,
  output logic                       edpClkEn,
  output logic                       ctlClkEn,
  output logic                       mrReset,
  output logic                       ebusDriving,
  output logic [ebusPkg::READ_W-1:0] ebusReadData
);
  import clkCtlPkg::*;

  // Decoded function pulses
  logic startFn;
  logic stepFn;
  logic burstFn;
  logic clrResetFn;
  logic setResetFn;
  logic ctlFnAny;
  logic ldBurstLo;
  logic ldBurstHi;
  logic ldRate;
  logic ldDisable;

  // Configuration and run state
  logic [SRC_W-1:0]   sourceSel;
  rateE               rateSel;
  logic               crmDis;
  logic               edpDis;
  logic               ctlDis;
  logic               run;
  logic               burst;
  logic [BURST_W-1:0] burstCount;
  logic               runReq;

  diagFuncDecoder decoderInst (
    .MBOX_CLK    (MBOX_CLK),
    .CLK         (CLK),
    .diagCtlFunc (diagCtlFunc),
    .diagLdFunc  (diagLdFunc),
    .ebusDs      (ebusDs),
    .startFn     (startFn),
    .stepFn      (stepFn),
    .burstFn     (burstFn),
    .clrResetFn  (clrResetFn),
    .setResetFn  (setResetFn),
    .ctlFnAny    (ctlFnAny),
    .ldBurstLo   (ldBurstLo),
    .ldBurstHi   (ldBurstHi),
    .ldRate      (ldRate),
    .ldDisable   (ldDisable)
  );

  clkConfigRegs configInst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .ldRate     (ldRate),
    .ldDisable  (ldDisable),
    .setResetFn (setResetFn),
    .clrResetFn (clrResetFn),
    .ebusData   (ebusData),
    .sourceSel  (sourceSel),
    .rateSel    (rateSel),
    .crmDis     (crmDis),
    .edpDis     (edpDis),
    .ctlDis     (ctlDis),
    .mrReset    (mrReset)
  );

  // Run requests paced by the rate divider
  burstControl #(
    .BURST_W (BURST_W)
  ) burstInst (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .startFn    (startFn),
    .stepFn     (stepFn),
    .burstFn    (burstFn),
    .ctlFnAny   (ctlFnAny),
    .ldBurstLo  (ldBurstLo),
    .ldBurstHi  (ldBurstHi),
    .ebusData   (ebusData),
    .rateSel    (rateSel),
    .run        (run),
    .burst      (burst),
    .burstCount (burstCount),
    .runReq     (runReq)
  );

  eboxSync #(
    .PHASE_W (PHASE_W)
  ) syncInst (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .runReq    (runReq),
    .cramTime  (cramTime),
    .crmDis    (crmDis),
    .edpDis    (edpDis),
    .ctlDis    (ctlDis),
    .eboxSync  (eboxSync),
    .eboxClkEn (eboxClkEn),
    .crmClkEn  (crmClkEn),
    .edpClkEn  (edpClkEn),
    .ctlClkEn  (ctlClkEn)
  );

  // Status readback onto EBUS bits 30..35
  diagReadMux #(
    .BURST_W (BURST_W)
  ) readInst (
    .MBOX_CLK     (MBOX_CLK),
    .CLK          (CLK),
    .diagRead     (diagRead),
    .ebusDs       (ebusDs),
    .eboxSync     (eboxSync),
    .run          (run),
    .burst        (burst),
    .mrReset      (mrReset),
    .burstCount   (burstCount),
    .sourceSel    (sourceSel),
    .rateSel      (rateSel),
    .crmDis       (crmDis),
    .edpDis       (edpDis),
    .ctlDis       (ctlDis),
    .ebusDriving  (ebusDriving),
    .ebusReadData (ebusReadData)
  );

endmodule

// File: bench/clkTbRef.svh
`ifndef CLK_TB_REF_SVH
`define CLK_TB_REF_SVH

// Status word, EBUS bit 30 first, low bit always zero
function automatic logic [5:0] statusWord(input logic sync, input logic runBit,
                                          input logic burstBit, input logic mr,
                                          input logic cntZero);
  return {sync, runBit, burstBit, mr, cntZero, 1'b0};
endfunction

function automatic logic [5:0] countHiWord(input logic [7:0] cnt);
  return {2'b00, cnt[7:4]};
endfunction

function automatic logic [5:0] countLoWord(input logic [7:0] cnt);
  return {2'b00, cnt[3:0]};
endfunction

// 044 data, bits 32..33 source and 34..35 rate
function automatic logic [5:0] configWord(input logic [3:0] data);
  return {data[3:2], data[1:0], 2'b00};
endfunction

// 045 data, bits 33..35 are CRM, EDP, CTL
function automatic logic [5:0] disableWord(input logic [3:0] data);
  return {data[2], data[1], data[0], 3'b000};
endfunction

function automatic int sectionCount(input int total, input logic disBit);
  return disBit ? 0 : total;
endfunction

// EBOX clocks from one burst, cycle 0 is the first rate tick with burst up
// Every tick spends a count, a sync only forms when phase and idle allow
function automatic int burstPulses(input int count, input int rate, input int cramT);
  int   period;
  int   phase;
  int   cyc;
  int   pulses;
  logic tick;
  logic sync;
  logic clkEn;
  logic syncReq;
  period = 1 << rate;
  // Long idle leaves the phase counter parked at its top value
  phase  = (1 << PHASE_W) - 1;
  sync   = 1'b0;
  clkEn  = 1'b0;
  cyc    = 0;
  pulses = 0;
  while (count != 0 || sync || clkEn) begin
    tick    = ((cyc % period) == 0);
    syncReq = tick && (count != 0) && (phase >= cramT) && !sync && !clkEn;
    if (clkEn) begin
      pulses++;
    end
    if (tick && count != 0) begin
      count--;
    end
    if (clkEn) begin
      phase = 0;
    end else if (phase < (1 << PHASE_W) - 1) begin
      phase++;
    end
    clkEn = sync;
    sync  = syncReq;
    cyc++;
  end
  return pulses;
endfunction

`endif

// File: bench/clkControlTb.sv
`timescale 1ns/1ps

module clkControlTb;
  import clkCtlPkg::*;
  import ebusPkg::*;

  logic               MBOX_CLK;
  logic               CLK;
  logic               diagCtlFunc;
  logic               diagLdFunc;
  logic [DS_W-1:0]    ebusDs;
  logic [LOAD_W-1:0]  ebusData;
  logic               diagRead;
  logic [PHASE_W-1:0] cramTime;
  logic               eboxSync;
  logic               eboxClkEn;
  logic               crmClkEn;
  logic               edpClkEn;
  logic               ctlClkEn;
  logic               mrReset;
  logic               ebusDriving;
  logic [READ_W-1:0]  ebusReadData;

  // Monitor counters cleared by the tests
  int   clkCount;
  int   crmCount;
  int   edpCount;
  int   ctlCount;
  logic prevSync;

  `include "clkTbRef.svh"

  clkControl #(
    .BURST_W (BURST_W),
    .PHASE_W (PHASE_W)
  ) clkControl_inst (
    .MBOX_CLK     (MBOX_CLK),
    .CLK          (CLK),
    .diagCtlFunc  (diagCtlFunc),
    .diagLdFunc   (diagLdFunc),
    .ebusDs       (ebusDs),
    .ebusData     (ebusData),
    .diagRead     (diagRead),
    .cramTime     (cramTime),
    .eboxSync     (eboxSync),
    .eboxClkEn    (eboxClkEn),
    .crmClkEn     (crmClkEn),
    .edpClkEn     (edpClkEn),
    .ctlClkEn     (ctlClkEn),
    .mrReset      (mrReset),
    .ebusDriving  (ebusDriving),
    .ebusReadData (ebusReadData)
  );

  // 20 ns MBOX clock
  always #10 MBOX_CLK = ~MBOX_CLK;

  task automatic abortRun(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic checkEq(input string testName, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("[ERROR] %s expected 0x%0h actual 0x%0h",
                         testName, expected, actual));
    end
  endtask

  // Inputs always change 2 ns after the rising edge
  task automatic stepClk();
    @(posedge MBOX_CLK);
    #2;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) stepClk();
  endtask

  task automatic clearCounts();
    clkCount = 0;
    crmCount = 0;
    edpCount = 0;
    ctlCount = 0;
  endtask

  // One-cycle strobe then two cycles for decode and latch update
  task automatic ctlFunction(input ctlFuncE code);
    ebusDs      = code;
    diagCtlFunc = 1'b1;
    stepClk();
    diagCtlFunc = 1'b0;
    idleCycles(2);
  endtask

  task automatic loadFunction(input ldFuncE code, input logic [LOAD_W-1:0] data);
    ebusDs     = code;
    ebusData   = data;
    diagLdFunc = 1'b1;
    stepClk();
    diagLdFunc = 1'b0;
    idleCycles(2);
  endtask

  // Raise diagRead and wait for the bus to be driven
  task automatic readBack(input logic [DS_W-1:0] sel, output logic [READ_W-1:0] word);
    int waited;
    waited   = 0;
    diagRead = 1'b1;
    ebusDs   = sel;
    @(posedge MBOX_CLK);
    @(negedge MBOX_CLK);
    while (!ebusDriving && waited < 8) begin
      @(negedge MBOX_CLK);
      waited++;
    end
    if (!ebusDriving) begin
      abortRun("EBUS was never driven during a diagnostic read");
    end
    word = ebusReadData;
    stepClk();
    diagRead = 1'b0;
  endtask

  task automatic waitPulses(input int target, input int limit, input string what);
    int waited;
    waited = 0;
    while (clkCount < target && waited < limit) begin
      stepClk();
      waited++;
    end
    if (clkCount < target) begin
      abortRun($sformatf("Timed out waiting for EBOX clocks during %s", what));
    end
  endtask

  // Counts EBOX clocks and checks that sync led each one
  always @(negedge MBOX_CLK) begin
    if (!CLK) begin
      if (eboxClkEn) begin
        checkEq("syncLead", 1, prevSync);
        clkCount++;
      end
      if (crmClkEn) crmCount++;
      if (edpClkEn) edpCount++;
      if (ctlClkEn) ctlCount++;
    end
    prevSync = eboxSync;
  end

  initial begin
    int                seed;
    int                count;
    int                expected;
    int                snapshot;
    logic [LOAD_W-1:0] data;
    logic [READ_W-1:0] word;
    MBOX_CLK    = 1'b0;
    CLK         = 1'b1;
    diagCtlFunc = 1'b0;
    diagLdFunc  = 1'b0;
    ebusDs      = '0;
    ebusData    = '0;
    diagRead    = 1'b0;
    cramTime    = '0;
    prevSync    = 1'b0;
    clearCounts();
    seed = $urandom(32'hd85f);
    repeat (10) @(posedge MBOX_CLK);
    #2;
    CLK = 1'b0;
    stepClk();

    // After reset then clear and set master reset
    checkEq("resetPin", 1, mrReset);
    readBack(rdStatus, word);
    checkEq("resetStatus", statusWord(0, 0, 0, 1, 1), word);
    ctlFunction(funcClrReset);
    readBack(rdStatus, word);
    checkEq("clrReset", statusWord(0, 0, 0, 0, 1), word);
    ctlFunction(funcSetReset);
    readBack(rdStatus, word);
    checkEq("setReset", statusWord(0, 0, 0, 1, 1), word);

    // 044 and 045 readback
    for (int i = 0; i < 6; i++) begin
      data = $urandom;
      loadFunction(ldFunc044, data);
      readBack(rdConfig, word);
      checkEq("configRead", configWord(data), word);
      data = $urandom;
      loadFunction(ldFunc045, data);
      readBack(rdDisable, word);
      checkEq("disableRead", disableWord(data), word);
    end

    // Burst at every rate
    for (int r = 0; r < 4; r++) begin
      count = 1 + ($urandom % 40);
      ctlFunction(funcStop);
      data = $urandom;
      data[1:0] = r;
      loadFunction(ldFunc044, data);
      loadFunction(ldFunc042, count[3:0]);
      loadFunction(ldFunc043, count[7:4]);
      readBack(rdCountHi, word);
      checkEq("burstCountHi", countHiWord(count[7:0]), word);
      readBack(rdCountLo, word);
      checkEq("burstCountLo", countLoWord(count[7:0]), word);
      cramTime = $urandom;
      expected = burstPulses(count, r, cramTime);
      clearCounts();
      ctlFunction(funcBurst);
      waitPulses(expected, count * 16 + 50, "burst");
      idleCycles(24);
      checkEq("burstPulses", expected, clkCount);
      readBack(rdStatus, word);
      checkEq("burstDone", statusWord(0, 0, 1, 1, 1), word);
    end

    // Single step, stop and the no-op codes
    ctlFunction(funcStop);
    loadFunction(ldFunc044, {2'b00, rateQuarter});
    for (int i = 0; i < 4; i++) begin
      cramTime = $urandom;
      clearCounts();
      ctlFunction(funcSingleStep);
      waitPulses(1, 40, "single step");
      idleCycles(12);
      checkEq("singleStep", 1, clkCount);
    end
    clearCounts();
    ctlFunction(funcStop);
    ctlFunction(funcEboxSs);
    ctlFunction(funcCondSs);
    idleCycles(20);
    checkEq("stopIdle", 0, clkCount);

    // Start runs until stop and only the in-flight cycle may finish afterwards
    cramTime = $urandom;
    clearCounts();
    ctlFunction(funcStart);
    waitPulses(8, 200, "start");
    ctlFunction(funcStop);
    idleCycles(4);
    snapshot = clkCount;
    idleCycles(30);
    checkEq("startStop", snapshot, clkCount);

    // Section disables with random time fields
    for (int i = 0; i < 5; i++) begin
      ctlFunction(funcStop);
      data = $urandom;
      loadFunction(ldFunc045, data);
      loadFunction(ldFunc044, {2'b00, rateEighth});
      count = 1 + ($urandom % 12);
      loadFunction(ldFunc042, count[3:0]);
      loadFunction(ldFunc043, count[7:4]);
      cramTime = $urandom;
      expected = burstPulses(count, rateEighth, cramTime);
      clearCounts();
      ctlFunction(funcBurst);
      waitPulses(expected, count * 16 + 50, "disable burst");
      idleCycles(24);
      checkEq("disablePulses", expected, clkCount);
      checkEq("crmCount", sectionCount(expected, data[2]), crmCount);
      checkEq("edpCount", sectionCount(expected, data[1]), edpCount);
      checkEq("ctlCount", sectionCount(expected, data[0]), ctlCount);
    end

    // Bus stays quiet without a read
    diagRead = 1'b0;
    idleCycles(2);
    for (int i = 0; i < 10; i++) begin
      ebusDs = $urandom;
      @(negedge MBOX_CLK);
      checkEq("noReadDriving", 0, ebusDriving);
      checkEq("noReadData", 0, ebusReadData);
      stepClk();
    end

    $display("Regression passed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+bench
verilog/clkCtlPkg.sv
verilog/ebusPkg.sv
verilog/diagFuncDecoder.sv
verilog/clkConfigRegs.sv
verilog/burstControl.sv
verilog/eboxSync.sv
verilog/diagReadMux.sv
verilog/clkControl.sv
bench/clkControlTb.sv

// File: Bender.yml
package:
  name: clkControl

sources:
  - files:
      - verilog/clkCtlPkg.sv
      - verilog/ebusPkg.sv
      - verilog/diagFuncDecoder.sv
      - verilog/clkConfigRegs.sv
      - verilog/burstControl.sv
      - verilog/eboxSync.sv
      - verilog/diagReadMux.sv
      - verilog/clkControl.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/clkControlTb.sv
